/* design/arcade_io_top.sv */
`timescale 1ns/1ps

module arcade_io_top #(
	parameter int CE_SLOW_DIV = arcade_pkg::CE_SLOW_DIV
) (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	// AXI4-Lite slave
	input  logic [3:0]               awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [31:0]              wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  logic [3:0]               araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	// Keyboard and sticks
	input  logic                     key_strobe,
	input  logic                     key_pressed,
	input  logic [7:0]               key_code,
	input  logic [7:0]               joystick_0,
	input  logic [7:0]               joystick_1,
	// Game video
	input  arcade_pkg::color4_t      red,
	input  arcade_pkg::color4_t      green,
	input  arcade_pkg::color4_t      blue,
	input  logic                     hblank,
	input  logic                     vblank,
	input  logic                     hsync,
	input  logic                     vsync,
	// Game core side
	output logic                     ce_12,
	output logic                     ce_6p,
	output logic                     ce_6n,
	output logic                     ce_1p79,
	output arcade_pkg::player_word_t player1_n,
	output arcade_pkg::player_word_t player2_n,
	output logic                     coin_n,
	output logic                     service_n,
	output logic                     game_reset,
	// VGA
	output arcade_pkg::color6_t      vga_r,
	output arcade_pkg::color6_t      vga_g,
	output arcade_pkg::color6_t      vga_b,
	output logic                     vga_hs,
	output logic                     vga_vs
);
	import arcade_pkg::*;

	btn_state_t buttons;

	io_cfg_if cfg_bus ();

	clk_enables #(
		.CE_SLOW_DIV(CE_SLOW_DIV)
	) clk_enables_i (
		.clk_sys, .arst_n, .ce_12, .ce_6p, .ce_6n, .ce_1p79
	);

	key_decoder key_decoder_i (
		.clk_sys, .arst_n, .key_strobe, .key_pressed, .key_code, .buttons
	);

	control_mapper control_mapper_i (
		.clk_sys, .arst_n, .buttons, .joystick_0, .joystick_1,
		.cfg(cfg_bus.sink),
		.player1_n, .player2_n, .coin_n, .service_n
	);

	video_out video_out_i (
		.clk_sys, .arst_n, .red, .green, .blue, .hblank, .vblank, .hsync, .vsync,
		.cfg(cfg_bus.sink),
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

	io_cfg_regs io_cfg_regs_i (
		.clk_sys, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.buttons,
		.cfg(cfg_bus.src)
	);

	assign game_reset = cfg_bus.soft_reset;   // Held while CTRL bit 4 is set

endmodule

/* design/arcade_pkg.sv */
package arcade_pkg;

	// ========================================================================
	// Player input types
	// ========================================================================

	// Held keyboard buttons, up is the top bit
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
	} btn_state_t;

	// Active-low word as the game core samples it
	typedef struct packed {
		logic start;
		logic fire;
		logic bomb;
		logic left;
		logic right;
		logic up;
		logic down;
	} player_word_t;

	// ========================================================================
	// Video types
	// ========================================================================

	typedef logic [3:0] color4_t;   // Game side
	typedef logic [5:0] color6_t;   // VGA side

	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scanline_t;

	// ========================================================================
	// Register map
	// ========================================================================

	localparam logic [3:0] ADDR_CTRL   = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;
	localparam logic [3:0] ADDR_ID     = 4'h8;

	localparam logic [31:0] IO_ID = 32'h414D_4452;

	// CTRL field positions
	localparam int CTRL_ROTATE  = 0;
	localparam int CTRL_SCAN_LO = 1;
	localparam int CTRL_SCAN_HI = 2;
	localparam int CTRL_SERVICE = 3;
	localparam int CTRL_SRESET  = 4;
	localparam int CTRL_WIDTH   = 5;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// PS/2 set 2 make codes
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_COIN   = 8'h76;   // Esc
	localparam logic [7:0] SC_START1 = 8'h05;   // F1
	localparam logic [7:0] SC_START2 = 8'h06;   // F2
	localparam logic [7:0] SC_FIRE1  = 8'h29;   // Space
	localparam logic [7:0] SC_FIRE2  = 8'h11;   // Alt

	// Slow strobe period minus one
	localparam int CE_SLOW_DIV = 13;

endpackage

/* design/clk_enables.sv */
`timescale 1ns/1ps

module clk_enables #(
	parameter int CE_SLOW_DIV = 13
) (
	input  logic clk_sys,
	input  logic arst_n,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam int SLOW_W = (CE_SLOW_DIV > 1) ? $clog2(CE_SLOW_DIV + 1) : 1;

	logic [1:0]        div_q;
	logic [SLOW_W-1:0] slow_q;

	// Four-phase counter for the fast strobes
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_q <= '0;
			ce_12 <= 1'b0;
			ce_6p <= 1'b0;
			ce_6n <= 1'b0;
		end else begin
			div_q <= div_q + 2'd1;
			ce_12 <= div_q[0];
			ce_6p <= div_q[0] & ~div_q[1];   // Phase 1
			ce_6n <= div_q[0] & div_q[1];    // Phase 3
		end
	end

	// Down counter, reload on zero
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			slow_q  <= SLOW_W'(CE_SLOW_DIV);
			ce_1p79 <= 1'b0;
		end else if (slow_q == '0) begin
			slow_q  <= SLOW_W'(CE_SLOW_DIV);
			ce_1p79 <= 1'b1;
		end else begin
			slow_q  <= slow_q - SLOW_W'(1);
			ce_1p79 <= 1'b0;
		end
	end

endmodule

/* design/control_mapper.sv */
`timescale 1ns/1ps

module control_mapper (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  arcade_pkg::btn_state_t   buttons,
	input  logic [7:0]               joystick_0,
	input  logic [7:0]               joystick_1,
	io_cfg_if.sink                   cfg,
	output arcade_pkg::player_word_t player1_n,
	output arcade_pkg::player_word_t player2_n,
	output logic                     coin_n,
	output logic                     service_n
);
	import arcade_pkg::*;

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic dir_up;
	logic dir_down;
	logic dir_left;
	logic dir_right;
	logic act_fire;
	logic act_bomb;

	// Keyboard OR both sticks per direction
	assign src_up    = buttons.up    | joystick_0[3] | joystick_1[3];
	assign src_down  = buttons.down  | joystick_0[2] | joystick_1[2];
	assign src_left  = buttons.left  | joystick_0[1] | joystick_1[1];
	assign src_right = buttons.right | joystick_0[0] | joystick_1[0];

	// Cabinet turned on its side
	assign dir_up    = cfg.rotate ? src_left  : src_up;
	assign dir_down  = cfg.rotate ? src_right : src_down;
	assign dir_left  = cfg.rotate ? src_down  : src_left;
	assign dir_right = cfg.rotate ? src_up    : src_right;

	assign act_fire = buttons.fire1 | joystick_0[4] | joystick_1[4];
	assign act_bomb = buttons.fire2 | joystick_0[5] | joystick_1[5];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			player1_n <= '1;   // Nothing pressed
			player2_n <= '1;
			coin_n    <= 1'b1;
		end else begin
			player1_n <= ~{buttons.start1, act_fire, act_bomb,
				dir_left, dir_right, dir_up, dir_down};
			player2_n <= ~{buttons.start2, act_fire, act_bomb,
				dir_left, dir_right, dir_up, dir_down};
			coin_n    <= ~buttons.coin;
		end
	end

	// Straight from the CTRL flop so it moves with the write response
	assign service_n = ~cfg.service;

endmodule

/* design/io_cfg_if.sv */
`timescale 1ns/1ps

interface io_cfg_if;
	import arcade_pkg::*;

	logic      rotate;
	scanline_t scanline;
	logic      service;
	logic      soft_reset;

	// Register block side
	modport src (
		output rotate, scanline, service, soft_reset
	);

	// Mapper and video side
	modport sink (
		input rotate, scanline, service, soft_reset
	);

endinterface

/* design/io_cfg_regs.sv */
`timescale 1ns/1ps

module io_cfg_regs (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	// AXI4-Lite write address and data
	input  logic [3:0]             awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [31:0]            wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	// Write response
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	// Read address and data
	input  logic [3:0]             araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	input  arcade_pkg::btn_state_t buttons,
	io_cfg_if.src                  cfg
);
	import arcade_pkg::*;

	logic [CTRL_WIDTH-1:0] ctrl_q;
	logic                  wr_accept;
	logic                  wr_mapped;
	logic                  rd_accept;
	logic                  rd_mapped;
	logic [31:0]           rd_word;

	// ========================================================================
	// Write channel
	// ========================================================================

	// Address and data together, one response outstanding
	assign wr_accept = awvalid & wvalid & ~bvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;

	assign wr_mapped = (awaddr == ADDR_CTRL) || (awaddr == ADDR_STATUS) ||
		(awaddr == ADDR_ID);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			ctrl_q <= '0;
		end else if (wr_accept) begin
			bvalid <= 1'b1;
			if (awaddr == ADDR_CTRL && wstrb[0])
				ctrl_q <= wdata[CTRL_WIDTH-1:0];   // STATUS and ID ignore writes
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_accept)
			bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
	end

	// ========================================================================
	// Read channel
	// ========================================================================

	assign rd_accept = arvalid & ~rvalid;
	assign arready   = rd_accept;

	always_comb begin
		rd_word   = '0;
		rd_mapped = 1'b1;
		case (araddr)
			ADDR_CTRL:   rd_word = {{(32 - CTRL_WIDTH){1'b0}}, ctrl_q};
			ADDR_STATUS: rd_word = {{(32 - $bits(btn_state_t)){1'b0}}, buttons};
			ADDR_ID:     rd_word = IO_ID;
			default:     rd_mapped = 1'b0;   // Zero data
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// Held until the master takes it
	always_ff @(posedge clk_sys) begin
		if (rd_accept) begin
			rdata <= rd_word;
			rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Settings out
	assign cfg.rotate     = ctrl_q[CTRL_ROTATE];
	assign cfg.scanline   = scanline_t'(ctrl_q[CTRL_SCAN_HI:CTRL_SCAN_LO]);
	assign cfg.service    = ctrl_q[CTRL_SERVICE];
	assign cfg.soft_reset = ctrl_q[CTRL_SRESET];

endmodule

/* design/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  logic [7:0]             key_code,
	output arcade_pkg::btn_state_t buttons
);
	import arcade_pkg::*;

	// Make sets a button, break clears it
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;   // All released
		end else if (key_strobe) begin
			case (key_code)
				SC_UP:     buttons.up     <= key_pressed;
				SC_DOWN:   buttons.down   <= key_pressed;
				SC_LEFT:   buttons.left   <= key_pressed;
				SC_RIGHT:  buttons.right  <= key_pressed;
				SC_COIN:   buttons.coin   <= key_pressed;
				SC_START1: buttons.start1 <= key_pressed;
				SC_START2: buttons.start2 <= key_pressed;
				SC_FIRE1:  buttons.fire1  <= key_pressed;
				SC_FIRE2:  buttons.fire2  <= key_pressed;
				default: begin
					// Other keys are not mapped
					buttons <= buttons;
				end
			endcase
		end
	end

endmodule

/* design/video_out.sv */
`timescale 1ns/1ps

module video_out (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  arcade_pkg::color4_t red,
	input  arcade_pkg::color4_t green,
	input  arcade_pkg::color4_t blue,
	input  logic                hblank,
	input  logic                vblank,
	input  logic                hsync,
	input  logic                vsync,
	io_cfg_if.sink              cfg,
	output arcade_pkg::color6_t vga_r,
	output arcade_pkg::color6_t vga_g,
	output arcade_pkg::color6_t vga_b,
	output logic                vga_hs,
	output logic                vga_vs
);
	import arcade_pkg::*;

	logic    hs_d;
	logic    vs_d;
	logic    odd_line;
	logic    blank;
	color6_t wide_r;
	color6_t wide_g;
	color6_t wide_b;

	// Darken a channel on odd lines
	function automatic color6_t dim(input color6_t c, input scanline_t mode, input logic odd);
		color6_t res;
		res = c;
		if (odd) begin
			case (mode)
				SCAN_OFF: res = c;
				SCAN_25:  res = c - (c >> 2);
				SCAN_50:  res = c >> 1;
				SCAN_75:  res = c >> 2;
			endcase
		end
		return res;
	endfunction

	assign blank  = hblank | vblank;
	assign wide_r = blank ? '0 : {red,   red[3:2]};   // Repeat top bits
	assign wide_g = blank ? '0 : {green, green[3:2]};
	assign wide_b = blank ? '0 : {blue,  blue[3:2]};

	// Line parity, restarts every frame
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_d <= hsync;
			vs_d <= vsync;
			if (vsync && !vs_d)
				odd_line <= 1'b0;
			else if (hsync && !hs_d)
				odd_line <= ~odd_line;
		end
	end

	// Output stage, syncs kept aligned with colour
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= dim(wide_r, cfg.scanline, odd_line);
			vga_g  <= dim(wide_g, cfg.scanline, odd_line);
			vga_b  <= dim(wide_b, cfg.scanline, odd_line);
			vga_hs <= ~hsync;
			vga_vs <= ~vsync;
		end
	end

endmodule

/* dv/arcade_io_checker.sv */
`timescale 1ns/1ps

module arcade_io_checker (
	input logic        clk_sys,
	input logic        arst_n,
	input logic        bvalid,
	input logic        bready,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input logic        ce_12,
	input logic        ce_6p,
	input logic        ce_6n
);

	// Responses stay up until the master takes them
	a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	a_rdata_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while rvalid waited");

	// The two 6 MHz phases
	a_ce6_apart: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce_6p && ce_6n))
		else $error("ce_6p and ce_6n high together");

	a_ce6_on_ce12: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(ce_6p || ce_6n) |-> ce_12)
		else $error("6 MHz strobe outside a 12 MHz cycle");

endmodule

/* dv/arcade_io_tb.sv */
`timescale 1ns/1ps

module arcade_io_tb;
	import arcade_pkg::*;

	localparam int CLK_NS     = 8;
	localparam int CE_CYCLES  = 280;
	localparam int REG_CYCLES = 16 * 20;
	localparam int KEY_CYCLES = 200 * 20;
	localparam int JOY_CYCLES = 2 * (40 + 20);
	localparam int VID_CYCLES = 304 + 4 * 20;
	localparam int WATCHDOG_NS = 2 * CLK_NS *
		(10 + CE_CYCLES + REG_CYCLES + KEY_CYCLES + JOY_CYCLES + VID_CYCLES);

	localparam logic [7:0] KNOWN_CODES [0:8] = '{SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT,
		SC_COIN, SC_START1, SC_START2, SC_FIRE1, SC_FIRE2};

	typedef struct {
		int           due;
		player_word_t p1;
		player_word_t p2;
		logic         coin;
	} player_exp_t;

	typedef struct {
		int      due;
		color6_t r;
		color6_t g;
		color6_t b;
		logic    hs;
		logic    vs;
	} video_exp_t;

	logic clk_sys;
	logic arst_n;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic key_strobe;
	logic key_pressed;
	logic [7:0] key_code;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	color4_t red;
	color4_t green;
	color4_t blue;
	logic hblank;
	logic vblank;
	logic hsync;
	logic vsync;
	logic ce_12;
	logic ce_6p;
	logic ce_6n;
	logic ce_1p79;
	player_word_t player1_n;
	player_word_t player2_n;
	logic coin_n;
	logic service_n;
	logic game_reset;
	color6_t vga_r;
	color6_t vga_g;
	color6_t vga_b;
	logic vga_hs;
	logic vga_vs;

	logic [31:0] lcg_state = 32'd78052;
	int          cyc = 0;
	int          value_errors = 0;
	int          proto_errors = 0;
	btn_state_t  btn_model;
	logic [4:0]  ctrl_model;
	logic        hs_m;
	logic        vs_m;
	logic        odd_m;
	player_exp_t player_q [$];
	video_exp_t  video_q [$];

	arcade_io_top #(
		.CE_SLOW_DIV(CE_SLOW_DIV)
	) arcade_io_top_i (.*);

	bind arcade_io_top arcade_io_checker arcade_io_checker_i (
		.clk_sys(clk_sys), .arst_n(arst_n), .bvalid(bvalid), .bready(bready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata),
		.ce_12(ce_12), .ce_6p(ce_6p), .ce_6n(ce_6n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) cyc <= cyc + 1;

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic btn_state_t apply_key(btn_state_t b, logic [7:0] code, logic pressed);
		case (code)
			SC_UP:     b.up = pressed;
			SC_DOWN:   b.down = pressed;
			SC_LEFT:   b.left = pressed;
			SC_RIGHT:  b.right = pressed;
			SC_COIN:   b.coin = pressed;
			SC_START1: b.start1 = pressed;
			SC_START2: b.start2 = pressed;
			SC_FIRE1:  b.fire1 = pressed;
			SC_FIRE2:  b.fire2 = pressed;
			default: ;
		endcase
		return b;
	endfunction

	function automatic player_word_t expected_player(btn_state_t b, logic [7:0] j0,
		logic [7:0] j1, logic rot, logic start);
		player_word_t p;
		logic up;
		logic down;
		logic left;
		logic right;
		up    = b.up | j0[3] | j1[3];
		down  = b.down | j0[2] | j1[2];
		left  = b.left | j0[1] | j1[1];
		right = b.right | j0[0] | j1[0];
		p.start = ~start;
		p.fire  = ~(b.fire1 | j0[4] | j1[4]);
		p.bomb  = ~(b.fire2 | j0[5] | j1[5]);
		p.up    = ~(rot ? left : up);
		p.down  = ~(rot ? right : down);
		p.left  = ~(rot ? down : left);
		p.right = ~(rot ? up : right);
		return p;
	endfunction

	function automatic color6_t expected_color(color4_t c, logic blank, scanline_t mode,
		logic odd);
		color6_t w;
		w = blank ? 6'd0 : {c, c[3:2]};
		if (odd) begin
			case (mode)
				SCAN_25: w = w - (w >> 2);
				SCAN_50: w = w >> 1;
				SCAN_75: w = w >> 2;
				default: ;
			endcase
		end
		return w;
	endfunction

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_player(string what, player_word_t got, player_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_color(string what, color6_t got, color6_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_data(string what, logic [31:0] got, logic [1:0] got_resp,
		logic [31:0] exp, logic [1:0] exp_resp);
		if (got !== exp || got_resp !== exp_resp) begin
			value_errors++;
			$display("[FAIL] %0d ns: %s is %h/%b, expected %h/%b", $time, what,
				got, got_resp, exp, exp_resp);
		end
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(string what, int got, int exp);
		if (got != exp) begin
			value_errors++;
			$display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Mid-cycle, after the registered outputs settle
	always @(negedge clk_sys) begin : compare_proc
		player_exp_t pe;
		video_exp_t  ve;
		while (player_q.size() > 0 && player_q[0].due <= cyc) begin
			pe = player_q.pop_front();
			check_player("player1_n", player1_n, pe.p1);
			check_player("player2_n", player2_n, pe.p2);
			check_bit("coin_n", coin_n, pe.coin);
		end
		while (video_q.size() > 0 && video_q[0].due <= cyc) begin
			ve = video_q.pop_front();
			check_color("vga_r", vga_r, ve.r);
			check_color("vga_g", vga_g, ve.g);
			check_color("vga_b", vga_b, ve.b);
			check_bit("vga_hs", vga_hs, ve.hs);
			check_bit("vga_vs", vga_vs, ve.vs);
		end
	end

	// ========================================================================
	// Bus and stimulus tasks, entered 1 ns after a rising edge
	// ========================================================================

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!(awready && wready) && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (!(awready && wready)) begin
			proto_errors++;
			$display("%0d ns: write to %h was never accepted", $time, addr);
		end
		@(posedge clk_sys);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk_sys);
		check_bit("bvalid after accept", bvalid, 1'b1);
		if (addr == ADDR_CTRL) begin
			check_bit("service_n", service_n, ~data[3]);   // Same edge as bvalid
			check_bit("game_reset", game_reset, data[4]);
		end
		repeat (int'(rand32() % 32'd4)) @(negedge clk_sys);
		@(posedge clk_sys);
		#1;
		bready = 1'b1;
		@(negedge clk_sys);
		check_bit("bvalid at bready", bvalid, 1'b1);
		resp = bresp;
		@(posedge clk_sys);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!arready && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (!arready) begin
			proto_errors++;
			$display("%0d ns: read of %h was never accepted", $time, addr);
		end
		@(posedge clk_sys);
		#1;
		arvalid = 1'b0;
		@(negedge clk_sys);
		check_bit("rvalid after accept", rvalid, 1'b1);
		repeat (int'(rand32() % 32'd4)) @(negedge clk_sys);
		@(posedge clk_sys);
		#1;
		rready = 1'b1;
		@(negedge clk_sys);
		check_bit("rvalid at rready", rvalid, 1'b1);
		data = rdata;
		resp = rresp;
		@(posedge clk_sys);
		#1;
		rready = 1'b0;
	endtask

	task automatic ctrl_write(input logic [31:0] data);
		logic [1:0] resp;
		axi_write(ADDR_CTRL, data, resp);
		check_data("CTRL write response", 32'd0, resp, 32'd0, RESP_OKAY);
		ctrl_model = data[4:0];
	endtask

	task automatic push_player(int latency);
		player_exp_t pe;
		pe.due  = cyc + latency;
		pe.p1   = expected_player(btn_model, joystick_0, joystick_1, ctrl_model[0],
			btn_model.start1);
		pe.p2   = expected_player(btn_model, joystick_0, joystick_1, ctrl_model[0],
			btn_model.start2);
		pe.coin = ~btn_model.coin;
		player_q.push_back(pe);
	endtask

	task automatic video_step(logic [31:0] r, logic hs, logic vs);
		video_exp_t ve;
		scanline_t  mode;
		red = r[3:0];
		green = r[7:4];
		blue = r[11:8];
		hblank = (r[14:12] == 3'd0);
		vblank = (r[17:15] == 3'd0);
		hsync = hs;
		vsync = vs;
		mode = scanline_t'(ctrl_model[2:1]);
		ve.due = cyc + 1;
		ve.r = expected_color(red, hblank | vblank, mode, odd_m);
		ve.g = expected_color(green, hblank | vblank, mode, odd_m);
		ve.b = expected_color(blue, hblank | vblank, mode, odd_m);
		ve.hs = ~hs;
		ve.vs = ~vs;
		video_q.push_back(ve);
		// Line parity as of the next edge
		if (vs && !vs_m)
			odd_m = 1'b0;
		else if (hs && !hs_m)
			odd_m = ~odd_m;
		hs_m = hs;
		vs_m = vs;
		@(posedge clk_sys);
		#1;
	endtask

	// ========================================================================
	// Test phases
	// ========================================================================

	task automatic test_clock_enables();
		int n12;
		int n6p;
		int n6n;
		int nslow;
		int last;
		n12 = 0;
		n6p = 0;
		n6n = 0;
		nslow = 0;
		last = -1;
		@(negedge clk_sys);   // Strobes still hold their reset values here
		for (int i = 0; i < CE_CYCLES; i++) begin
			@(negedge clk_sys);
			n12 += int'(ce_12);
			n6p += int'(ce_6p);
			n6n += int'(ce_6n);
			if (ce_1p79) begin
				if (last >= 0)
					check_count("ce_1p79 spacing", i - last, CE_SLOW_DIV + 1);
				last = i;
				nslow++;
			end
		end
		check_count("ce_12 pulses", n12, CE_CYCLES / 2);
		check_count("ce_6p pulses", n6p, CE_CYCLES / 4);
		check_count("ce_6n pulses", n6n, CE_CYCLES / 4);
		check_count("ce_1p79 pulses", nslow, CE_CYCLES / (CE_SLOW_DIV + 1));
		@(posedge clk_sys);
		#1;
	endtask

	task automatic test_registers();
		logic [31:0] d;
		logic [31:0] r;
		logic [1:0]  resp;
		repeat (6) begin
			r = rand32();
			ctrl_write(r);
			axi_read(ADDR_CTRL, d, resp);
			check_data("CTRL readback", d, resp, {27'd0, r[4:0]}, RESP_OKAY);
		end
		axi_read(ADDR_ID, d, resp);
		check_data("ID", d, resp, IO_ID, RESP_OKAY);
		axi_read(4'hC, d, resp);
		check_data("unmapped read", d, resp, 32'd0, RESP_SLVERR);
		axi_write(ADDR_ID, ~IO_ID, resp);
		check_data("ID write response", 32'd0, resp, 32'd0, RESP_OKAY);
		axi_read(ADDR_ID, d, resp);
		check_data("ID after write", d, resp, IO_ID, RESP_OKAY);
		axi_write(4'hC, rand32(), resp);
		check_data("unmapped write response", 32'd0, resp, 32'd0, RESP_SLVERR);
		axi_read(ADDR_CTRL, d, resp);
		check_data("CTRL after unmapped write", d, resp, {27'd0, ctrl_model}, RESP_OKAY);
		axi_read(ADDR_STATUS, d, resp);
		check_data("STATUS idle", d, resp, 32'(btn_model), RESP_OKAY);
		ctrl_write(32'd0);
	endtask

	task automatic test_keys();
		logic [31:0] d;
		logic [31:0] r;
		logic [1:0]  resp;
		repeat (200) begin
			r = rand32();
			if (r[1:0] == 2'd0)
				key_code = r[23:16];   // Mostly unmapped
			else
				key_code = KNOWN_CODES[4'((r >> 8) % 32'd9)];
			key_pressed = r[2];
			key_strobe = 1'b1;
			btn_model = apply_key(btn_model, key_code, key_pressed);
			push_player(2);
			@(posedge clk_sys);
			#1;
			key_strobe = 1'b0;
			@(posedge clk_sys);
			#1;
			axi_read(ADDR_STATUS, d, resp);
			check_data("STATUS", d, resp, 32'(btn_model), RESP_OKAY);
		end
	endtask

	task automatic test_joysticks();
		logic [31:0] r;
		for (int rot = 0; rot < 2; rot++) begin
			ctrl_write(32'(rot));
			repeat (40) begin
				r = rand32();
				joystick_0 = r[7:0];
				joystick_1 = r[15:8];
				push_player(1);
				@(posedge clk_sys);
				#1;
			end
		end
		joystick_0 = 8'd0;
		joystick_1 = 8'd0;
		ctrl_write(32'd0);
	endtask

	task automatic test_video();
		int k;
		k = 0;
		for (int s = 0; s < 4; s++) begin
			ctrl_write(32'(s << 1));
			repeat (75) begin
				video_step(rand32(), (k % 12) < 2, (k % 100) >= 96);
				k++;
			end
			video_step(rand32(), 1'b0, 1'b0);   // Park the syncs low
		end
		ctrl_write(32'd0);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin : main
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		red = '0;
		green = '0;
		blue = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		btn_model = '0;
		ctrl_model = '0;
		hs_m = 1'b0;
		vs_m = 1'b0;
		odd_m = 1'b0;

		repeat (9) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("strobes in reset", ce_12 | ce_6p | ce_6n | ce_1p79, 1'b0);
		check_bit("bvalid in reset", bvalid, 1'b0);
		check_bit("rvalid in reset", rvalid, 1'b0);
		check_player("player1_n in reset", player1_n, '1);
		check_player("player2_n in reset", player2_n, '1);
		check_bit("coin_n in reset", coin_n, 1'b1);
		check_bit("service_n in reset", service_n, 1'b1);
		check_bit("game_reset in reset", game_reset, 1'b0);
		check_color("vga_r in reset", vga_r, '0);
		check_color("vga_g in reset", vga_g, '0);
		check_color("vga_b in reset", vga_b, '0);
		@(posedge clk_sys);
		#1;
		arst_n = 1'b1;

		test_clock_enables();
		test_registers();
		test_keys();
		test_joysticks();
		test_video();

		repeat (4) @(posedge clk_sys);
		if (player_q.size() != 0 || video_q.size() != 0) begin
			proto_errors++;
			$display("%0d ns: expected results were left unchecked", $time);
		end
		$display("checks done: %0d value errors, %0d protocol errors",
			value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Twice the planned length of all phases
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the arcade I/O testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module arcade_io_tb -o arcade_io_sim

out=$(./obj_dir/arcade_io_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

/* tb.f */
design/arcade_pkg.sv
design/io_cfg_if.sv
design/clk_enables.sv
design/key_decoder.sv
design/control_mapper.sv
design/video_out.sv
design/io_cfg_regs.sv
design/arcade_io_top.sv
dv/arcade_io_checker.sv
dv/arcade_io_tb.sv
